// File: common/dbg_mem_settings.svh
`ifndef DBG_MEM_SETTINGS_SVH
`define DBG_MEM_SETTINGS_SVH

// --------------------
// sizes
// --------------------
`define DBG_NR_HARTS      4
`define DBG_HARTSEL_W     2
`define DBG_DATA_COUNT    2
`define DBG_PROGBUF_SIZE  8
// only the low address bits are decoded
`define DBG_ADDR_BITS     12

// --------------------
// address map
// --------------------
// hart mailbox, written by the hart from the debug ROM
`define DBG_HALTED_ADDR     12'h100
`define DBG_GOING_ADDR      12'h104
`define DBG_RESUMING_ADDR   12'h108
`define DBG_EXCEPTION_ADDR  12'h10C
// variable jump slot
`define DBG_WHERETO_ADDR    12'h300
// data registers, program buffer right below, command table below that
`define DBG_DATA_ADDR       12'h380
`define DBG_PROGBUF_ADDR    12'h360
`define DBG_ABSCMD_ADDR     12'h338
// one flag byte per hart
`define DBG_FLAGS_ADDR      12'h400
`define DBG_FLAGS_END       12'h7FF
// ROM area, reads zero here
`define DBG_HALT_ADDR       12'h800
`define DBG_RESUME_ADDR     12'h808

`endif

// File: common/dbg_mem_pkg.sv
`default_nettype none

package dbg_mem_pkg;

  // sequencer state for the selected hart
  typedef enum logic [1:0] {
    Idle,
    Go,
    Resume,
    CmdExecuting
  } hart_state_e;

  // abstract command type field
  typedef enum logic [7:0] {
    AccessRegister = 8'd0,
    QuickAccess    = 8'd1,
    AccessMemory   = 8'd2
  } cmdtype_e;

  // abstractcs.cmderr encoding
  typedef enum logic [2:0] {
    CmdErrNone         = 3'd0,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3,
    CmdErrHaltResume   = 3'd4
  } cmderr_e;

  // control word of the command, access register layout
  //   22..20 aarsize, 19 postincrement, 18 postexec, 17 transfer, 16 write, 15..0 regno
  typedef logic [23:0] control_t;
  typedef logic [15:0] regno_t;
  typedef logic [2:0]  aarsize_t;

  typedef logic [31:0] instr_t;

  // --------------------
  // RV32 encoders
  // --------------------
  // jal rd, imm (J-type, imm is byte offset)
  function automatic instr_t jal(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // lb/lh/lw, funct3 is the access size
  function automatic instr_t load(input aarsize_t size, input logic [4:0] dest,
                                  input logic [4:0] base, input logic [11:0] offset);
    return {offset, base, size, dest, 7'h03};
  endfunction

  // sb/sh/sw, S-type immediate split around rs1
  function automatic instr_t store(input aarsize_t size, input logic [4:0] src,
                                   input logic [4:0] base, input logic [11:0] offset);
    return {offset[11:5], src, base, size, offset[4:0], 7'h23};
  endfunction

  function automatic instr_t ebreak();
    return 32'h0010_0073;
  endfunction

  // addi x0, x0, 0
  function automatic instr_t nop();
    return 32'h0000_0013;
  endfunction

  // all zeros traps as illegal
  function automatic instr_t illegal();
    return 32'h0000_0000;
  endfunction

endpackage

`default_nettype wire

// File: abstract_cmd/abstract_cmd_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbg_mem_settings.svh"

module abstract_cmd_gen (
  input  wire dbg_mem_pkg::cmdtype_e      cmdtype_i,
  input  wire dbg_mem_pkg::control_t      control_i,
  output      dbg_mem_pkg::instr_t [9:0]  abscmd_o,
  output      logic                       unsupported_o
);

  // largest supported access is 32 bits
  localparam int unsigned MaxAar = 3;

  dbg_mem_pkg::aarsize_t aarsize;
  dbg_mem_pkg::regno_t   regno;
  logic                  postincrement;
  logic                  postexec;
  logic                  transfer;
  logic                  write;
  logic                  gpr_access;

  // split the access register fields
  assign aarsize       = control_i[22:20];
  assign postincrement = control_i[19];
  assign postexec      = control_i[18];
  assign transfer      = control_i[17];
  assign write         = control_i[16];
  assign regno         = control_i[15:0];

  // 0x1000..0x101f, everything else is csr, fpr or reserved
  assign gpr_access = (regno[15:14] == 2'b00) && regno[12] && !regno[5];

  always_comb begin
    unsupported_o = 1'b0;
    // default table: trap, padding, then back to the park loop
    abscmd_o[0] = dbg_mem_pkg::illegal();
    for (int i = 1; i < 8; i++) begin
      abscmd_o[i] = dbg_mem_pkg::nop();
    end
    abscmd_o[8] = dbg_mem_pkg::ebreak();
    abscmd_o[9] = '0;

    case (cmdtype_i)
      // --------------------
      // access register
      // --------------------
      dbg_mem_pkg::AccessRegister: begin
        if (!transfer) begin
          // nothing to move, may still run the program buffer
          abscmd_o[0] = dbg_mem_pkg::nop();
        end else if (32'(aarsize) < MaxAar && !postincrement && gpr_access) begin
          abscmd_o[0] = dbg_mem_pkg::nop();
          // zero page, so x0 is the base for the data window
          if (write) begin
            abscmd_o[4] = dbg_mem_pkg::load(aarsize, regno[4:0], 5'd0, `DBG_DATA_ADDR);
          end else begin
            abscmd_o[4] = dbg_mem_pkg::store(aarsize, regno[4:0], 5'd0, `DBG_DATA_ADDR);
          end
        end else begin
          // fpr, csr, reserved range, wide size or postincrement
          abscmd_o[0]   = dbg_mem_pkg::ebreak();
          unsupported_o = 1'b1;
        end

        // fall through into the program buffer instead of returning
        if (postexec && !unsupported_o) begin
          abscmd_o[8] = dbg_mem_pkg::nop();
        end
      end
      // quick access and memory access are not handled
      default: begin
        abscmd_o[0]   = dbg_mem_pkg::ebreak();
        unsupported_o = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/hart_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbg_mem_settings.svh"

module hart_ctrl_fsm (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic [`DBG_HARTSEL_W-1:0] hartsel_i,
  input  wire logic [`DBG_NR_HARTS-1:0]  haltreq_i,
  input  wire logic [`DBG_NR_HARTS-1:0]  resumereq_i,
  input  wire logic                      cmd_valid_i,
  input  wire logic                      unsupported_i,
  input  wire logic [`DBG_NR_HARTS-1:0]  halted_i,
  input  wire logic [`DBG_NR_HARTS-1:0]  resuming_i,
  input  wire logic                      going_i,
  input  wire logic [`DBG_NR_HARTS-1:0]  halted_written_i,
  input  wire logic                      exception_i,
  output      logic                      go_o,
  output      logic                      resume_o,
  output      logic                      cmdbusy_o,
  output      logic                      cmderror_valid_o,
  output      dbg_mem_pkg::cmderr_e      cmderror_o
);

  dbg_mem_pkg::hart_state_e state_d, state_q;

  always_comb begin
    state_d          = state_q;
    go_o             = 1'b0;
    resume_o         = 1'b0;
    cmdbusy_o        = 1'b1;
    cmderror_valid_o = 1'b0;
    cmderror_o       = dbg_mem_pkg::CmdErrNone;

    case (state_q)
      dbg_mem_pkg::Idle: begin
        cmdbusy_o = 1'b0;
        // a command only starts on a halted hart
        if (cmd_valid_i && halted_i[hartsel_i] && !unsupported_i) begin
          state_d = dbg_mem_pkg::Go;
        end
        // resume is ignored while a halt is pending or the last ack is not cleared
        if (resumereq_i[hartsel_i] && !resuming_i[hartsel_i] &&
            !haltreq_i[hartsel_i] && halted_i[hartsel_i]) begin
          state_d = dbg_mem_pkg::Resume;
        end
      end
      dbg_mem_pkg::Go: begin
        // flag byte releases the hart into whereto
        go_o = 1'b1;
        if (going_i) begin
          state_d = dbg_mem_pkg::CmdExecuting;
        end
      end
      dbg_mem_pkg::Resume: begin
        resume_o = 1'b1;
        if (resuming_i[hartsel_i]) begin
          state_d = dbg_mem_pkg::Idle;
        end
      end
      dbg_mem_pkg::CmdExecuting: begin
        // hart re-enters the park loop when done
        if (halted_written_i[hartsel_i]) begin
          state_d = dbg_mem_pkg::Idle;
        end
      end
      default: state_d = dbg_mem_pkg::Idle;
    endcase

    // --------------------
    // command errors, lowest priority first
    // --------------------
    if (cmd_valid_i && !halted_i[hartsel_i]) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = dbg_mem_pkg::CmdErrHaltResume;
    end
    // reported once per command so cmderr can be cleared afterwards
    if (cmd_valid_i && unsupported_i) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = dbg_mem_pkg::CmdErrNotSupported;
    end
    if (exception_i) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = dbg_mem_pkg::CmdErrException;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= dbg_mem_pkg::Idle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// File: src/dbg_mem_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbg_mem_settings.svh"

module dbg_mem_bus (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic                              req_i,
  input  wire logic                              we_i,
  input  wire logic [31:0]                       addr_i,
  input  wire logic [31:0]                       wdata_i,
  input  wire logic [3:0]                        be_i,
  input  wire logic [`DBG_HARTSEL_W-1:0]         hartsel_i,
  input  wire logic [`DBG_NR_HARTS-1:0]          resumereq_i,
  input  wire logic                              clear_resumeack_i,
  input  wire logic [`DBG_DATA_COUNT*32-1:0]     data_i,
  input  wire logic [`DBG_PROGBUF_SIZE*32-1:0]   progbuf_i,
  input  wire dbg_mem_pkg::cmdtype_e             cmdtype_i,
  input  wire dbg_mem_pkg::control_t             control_i,
  input  wire dbg_mem_pkg::instr_t [9:0]         abscmd_i,
  input  wire logic                              go_i,
  input  wire logic                              resume_i,
  input  wire logic                              cmdbusy_i,
  output      logic [31:0]                       rdata_o,
  output      logic [`DBG_NR_HARTS-1:0]          halted_o,
  output      logic [`DBG_NR_HARTS-1:0]          resuming_o,
  output      logic                              going_o,
  output      logic [`DBG_NR_HARTS-1:0]          halted_written_o,
  output      logic                              exception_o,
  output      logic [`DBG_DATA_COUNT*32-1:0]     data_o,
  output      logic                              data_valid_o
);

  localparam int unsigned AW = `DBG_ADDR_BITS;

  localparam logic [AW-1:0] DataEnd    = `DBG_DATA_ADDR + 4*`DBG_DATA_COUNT - 1;
  localparam logic [AW-1:0] ProgbufEnd = `DBG_DATA_ADDR - 1;
  localparam logic [AW-1:0] AbscmdEnd  = `DBG_PROGBUF_ADDR - 1;

  logic [AW-1:0]               addr;
  logic [`DBG_HARTSEL_W-1:0]   wdata_hartsel;
  logic [AW-1:0]               data_off;
  logic [AW-1:0]               progbuf_off;
  logic [AW-1:0]               abscmd_off;
  logic [AW-1:0]               flags_off;
  logic [`DBG_NR_HARTS-1:0]    halted_d, halted_q;
  logic [`DBG_NR_HARTS-1:0]    resuming_d, resuming_q;
  logic [31:0]                 rdata_d, rdata_q;
  logic                        shortcut;

  assign addr          = addr_i[AW-1:0];
  assign wdata_hartsel = wdata_i[`DBG_HARTSEL_W-1:0];

  // byte offsets into each window, word index is [..:2]
  assign data_off    = addr - `DBG_DATA_ADDR;
  assign progbuf_off = addr - `DBG_PROGBUF_ADDR;
  assign abscmd_off  = addr - `DBG_ABSCMD_ADDR;
  assign flags_off   = addr - `DBG_FLAGS_ADDR;

  // transfer-less access register with postexec goes straight to the program buffer
  assign shortcut = (cmdtype_i == dbg_mem_pkg::AccessRegister) &&
                    !control_i[17] && control_i[18];

  assign halted_o   = halted_q;
  assign resuming_o = resuming_q;
  assign rdata_o    = rdata_q;

  always_comb begin
    halted_d         = halted_q;
    resuming_d       = resuming_q;
    rdata_d          = rdata_q;
    data_o           = data_i;
    data_valid_o     = 1'b0;
    going_o          = 1'b0;
    exception_o      = 1'b0;
    halted_written_o = '0;

    // debugger acknowledges the resume
    if (clear_resumeack_i) begin
      resuming_d[hartsel_i] = 1'b0;
    end

    if (req_i && we_i) begin
      // --------------------
      // hart writes
      // --------------------
      case (addr) inside
        `DBG_HALTED_ADDR: begin
          halted_d[wdata_hartsel]         = 1'b1;
          halted_written_o[wdata_hartsel] = 1'b1;
        end
        `DBG_GOING_ADDR: going_o = 1'b1;
        `DBG_RESUMING_ADDR: begin
          // hart has left the park loop
          halted_d[wdata_hartsel]   = 1'b0;
          resuming_d[wdata_hartsel] = 1'b1;
        end
        `DBG_EXCEPTION_ADDR: exception_o = 1'b1;
        [`DBG_DATA_ADDR:DataEnd]: begin
          data_valid_o = 1'b1;
          for (int i = 0; i < 4; i++) begin
            if (be_i[i]) begin
              data_o[data_off[AW-1:2]*32 + i*8 +: 8] = wdata_i[i*8 +: 8];
            end
          end
        end
        default: ;
      endcase
    end else if (req_i) begin
      // --------------------
      // hart reads
      // --------------------
      rdata_d = '0;
      case (addr) inside
        `DBG_WHERETO_ADDR: begin
          if (resumereq_i[wdata_hartsel]) begin
            rdata_d = dbg_mem_pkg::jal(5'd0, 21'(`DBG_RESUME_ADDR - `DBG_WHERETO_ADDR));
          end
          // an active command wins over resume
          if (cmdbusy_i && shortcut) begin
            rdata_d = dbg_mem_pkg::jal(5'd0, 21'(`DBG_PROGBUF_ADDR - `DBG_WHERETO_ADDR));
          end else if (cmdbusy_i) begin
            rdata_d = dbg_mem_pkg::jal(5'd0, 21'(`DBG_ABSCMD_ADDR - `DBG_WHERETO_ADDR));
          end
        end
        [`DBG_DATA_ADDR:DataEnd]: rdata_d = data_i[data_off[AW-1:2]*32 +: 32];
        [`DBG_PROGBUF_ADDR:ProgbufEnd]: begin
          rdata_d = progbuf_i[progbuf_off[AW-1:2]*32 +: 32];
        end
        [`DBG_ABSCMD_ADDR:AbscmdEnd]: rdata_d = abscmd_i[abscmd_off[AW-1:2]];
        [`DBG_FLAGS_ADDR:`DBG_FLAGS_END]: begin
          // four harts per word, only the selected hart sees its flags
          if (flags_off[AW-1:2] == (AW-2)'(hartsel_i >> 2)) begin
            rdata_d[hartsel_i[1:0]*8 +: 8] = {6'b0, resume_i, go_i};
          end
        end
        // rom area and holes read zero
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      halted_q   <= '0;
      resuming_q <= '0;
      rdata_q    <= '0;
    end else begin
      halted_q   <= halted_d;
      resuming_q <= resuming_d;
      rdata_q    <= rdata_d;
    end
  end

endmodule

`default_nettype wire

// File: src/dbg_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbg_mem_settings.svh"

module dbg_mem_top (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  // debugger side
  input  wire logic [`DBG_HARTSEL_W-1:0]         hartsel_i,
  input  wire logic [`DBG_NR_HARTS-1:0]          haltreq_i,
  input  wire logic [`DBG_NR_HARTS-1:0]          resumereq_i,
  input  wire logic                              clear_resumeack_i,
  output      logic [`DBG_NR_HARTS-1:0]          debug_req_o,
  output      logic [`DBG_NR_HARTS-1:0]          halted_o,
  output      logic [`DBG_NR_HARTS-1:0]          resuming_o,
  input  wire logic                              cmd_valid_i,
  input  wire dbg_mem_pkg::cmdtype_e             cmdtype_i,
  input  wire dbg_mem_pkg::control_t             cmd_control_i,
  output      logic                              cmdbusy_o,
  output      logic                              cmderror_valid_o,
  output      dbg_mem_pkg::cmderr_e              cmderror_o,
  input  wire logic [`DBG_PROGBUF_SIZE*32-1:0]   progbuf_i,
  input  wire logic [`DBG_DATA_COUNT*32-1:0]     data_i,
  output      logic [`DBG_DATA_COUNT*32-1:0]     data_o,
  output      logic                              data_valid_o,
  // hart side memory port
  input  wire logic                              req_i,
  input  wire logic                              we_i,
  input  wire logic [31:0]                       addr_i,
  input  wire logic [31:0]                       wdata_i,
  input  wire logic [3:0]                        be_i,
  output      logic [31:0]                       rdata_o
);

  logic                       go;
  logic                       resume;
  logic                       going;
  logic                       exception;
  logic                       unsupported;
  logic [`DBG_NR_HARTS-1:0]   halted_written;
  dbg_mem_pkg::instr_t [9:0]  abscmd;

  // halt requests go straight to the harts
  assign debug_req_o = haltreq_i;

  hart_ctrl_fsm u_hart_ctrl_fsm (
    .clk_i,
    .rst_ni,
    .hartsel_i,
    .haltreq_i,
    .resumereq_i,
    .cmd_valid_i,
    .unsupported_i    (unsupported),
    .halted_i         (halted_o),
    .resuming_i       (resuming_o),
    .going_i          (going),
    .halted_written_i (halted_written),
    .exception_i      (exception),
    .go_o             (go),
    .resume_o         (resume),
    .cmdbusy_o,
    .cmderror_valid_o,
    .cmderror_o
  );

  abstract_cmd_gen u_abstract_cmd_gen (
    .cmdtype_i,
    .control_i     (cmd_control_i),
    .abscmd_o      (abscmd),
    .unsupported_o (unsupported)
  );

  dbg_mem_bus u_dbg_mem_bus (
    .clk_i,
    .rst_ni,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .be_i,
    .hartsel_i,
    .resumereq_i,
    .clear_resumeack_i,
    .data_i,
    .progbuf_i,
    .cmdtype_i,
    .control_i         (cmd_control_i),
    .abscmd_i          (abscmd),
    .go_i              (go),
    .resume_i          (resume),
    .cmdbusy_i         (cmdbusy_o),
    .rdata_o,
    .halted_o,
    .resuming_o,
    .going_o           (going),
    .halted_written_o  (halted_written),
    .exception_o       (exception),
    .data_o,
    .data_valid_o
  );

endmodule

`default_nettype wire

// File: verification/tb_dbg_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbg_mem_settings.svh"

module tb_dbg_mem;

  localparam int BusyTimeout = 20;
  // standard RV32 words used by the table
  localparam logic [31:0] NopWord    = 32'h0000_0013;
  localparam logic [31:0] EbreakWord = 32'h0010_0073;

  logic                              clk_i = 1'b0;
  logic                              rst_ni;
  logic [`DBG_HARTSEL_W-1:0]         hartsel_i;
  logic [`DBG_NR_HARTS-1:0]          haltreq_i;
  logic [`DBG_NR_HARTS-1:0]          resumereq_i;
  logic                              clear_resumeack_i;
  logic [`DBG_NR_HARTS-1:0]          debug_req_o;
  logic [`DBG_NR_HARTS-1:0]          halted_o;
  logic [`DBG_NR_HARTS-1:0]          resuming_o;
  logic                              cmd_valid_i;
  dbg_mem_pkg::cmdtype_e             cmdtype_i;
  logic [23:0]                       cmd_control_i;
  logic                              cmdbusy_o;
  logic                              cmderror_valid_o;
  dbg_mem_pkg::cmderr_e              cmderror_o;
  logic [`DBG_PROGBUF_SIZE*32-1:0]   progbuf_i;
  logic [`DBG_DATA_COUNT*32-1:0]     data_i;
  logic [`DBG_DATA_COUNT*32-1:0]     data_o;
  logic                              data_valid_o;
  logic                              req_i;
  logic                              we_i;
  logic [31:0]                       addr_i;
  logic [31:0]                       wdata_i;
  logic [3:0]                        be_i;
  logic [31:0]                       rdata_o;

  int          errors;
  int          checks;
  int          timeouts;
  int          hart;
  int          other_hart;
  int          gpr;
  int          idx;
  logic [31:0] rd_word;
  logic [31:0] wd_word;
  logic [3:0]  be;
  // pulses seen while the last request or command was on the inputs
  logic        err_valid_seen;
  logic [2:0]  err_seen;
  logic        data_valid_seen;
  logic [63:0] data_seen;
  logic        exc_write;

  // 100 ns period
  always #50 clk_i = ~clk_i;

  dbg_mem_top dut (
    .clk_i,
    .rst_ni,
    .hartsel_i,
    .haltreq_i,
    .resumereq_i,
    .clear_resumeack_i,
    .debug_req_o,
    .halted_o,
    .resuming_o,
    .cmd_valid_i,
    .cmdtype_i,
    .cmd_control_i,
    .cmdbusy_o,
    .cmderror_valid_o,
    .cmderror_o,
    .progbuf_i,
    .data_i,
    .data_o,
    .data_valid_o,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .be_i,
    .rdata_o
  );

  // --------------------
  // concurrent checks
  // --------------------
  // halt request is a straight wire to the harts
  assert property (@(posedge clk_i) debug_req_o == haltreq_i)
    else begin
      $display("FAILED %0t ns: debug_req_o %h differs from haltreq_i %h",
               $time, debug_req_o, haltreq_i);
      errors++;
    end

  // hart write into the exception mailbox
  assign exc_write = req_i && we_i &&
                     addr_i[`DBG_ADDR_BITS-1:0] == `DBG_EXCEPTION_ADDR;

  // exception code needs the mailbox write, any other code needs a command pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   cmderror_valid_o |-> (cmderror_o == dbg_mem_pkg::CmdErrException ?
                                         exc_write : cmd_valid_i))
    else begin
      $display("FAILED %0t ns: cmderror_valid_o with code %0d and no matching cause",
               $time, cmderror_o);
      errors++;
    end

  // --------------------
  // reference encoders
  // --------------------
  // J-type, rd fixed to x0
  function automatic logic [31:0] jal_word(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
  endfunction

  // S-type with x0 as base
  function automatic logic [31:0] store_word(input logic [2:0] size, input logic [4:0] rs2,
                                             input logic [11:0] off);
    return {off[11:5], rs2, 5'd0, size, off[4:0], 7'b0100011};
  endfunction

  // I-type with x0 as base
  function automatic logic [31:0] load_word(input logic [2:0] size, input logic [4:0] rd,
                                            input logic [11:0] off);
    return {off, 5'd0, size, rd, 7'b0000011};
  endfunction

  function automatic logic [23:0] make_control(input logic postexec, input logic transfer,
                                               input logic write, input logic [15:0] regno);
    // aarsize 2 means a 32 bit access
    return {1'b0, 3'd2, 1'b0, postexec, transfer, write, regno};
  endfunction

  // data image after a byte-enabled write to one word
  function automatic logic [63:0] merge_bytes(input logic [63:0] base, input int word,
                                              input logic [31:0] wd, input logic [3:0] en);
    logic [63:0] res;
    res = base;
    for (int b = 0; b < 4; b++) begin
      if (en[b]) begin
        res[word*32 + b*8 +: 8] = wd[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // --------------------
  // helpers
  // --------------------
  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    checks++;
    assert (got === exp)
      else begin
        $display("FAILED %0t ns: %s got %h expected %h", $time, what, got, exp);
        errors++;
      end
  endtask

  task automatic capture_pulses();
    err_valid_seen  = cmderror_valid_o;
    err_seen        = cmderror_o;
    data_valid_seen = data_valid_o;
    data_seen       = data_o;
  endtask

  // side effects are visible at the negedge this task ends on
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wd,
                           input logic [3:0] en);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= 1'b1;
    addr_i  <= addr;
    wdata_i <= wd;
    be_i    <= en;
    @(negedge clk_i);
    capture_pulses();
    @(posedge clk_i);
    req_i <= 1'b0;
    we_i  <= 1'b0;
    @(negedge clk_i);
  endtask

  // wd carries the hart index for the whereto lookup
  task automatic bus_read(input logic [31:0] addr, input logic [31:0] wd,
                          output logic [31:0] data);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= 1'b0;
    addr_i  <= addr;
    wdata_i <= wd;
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    data = rdata_o;
  endtask

  // type and control stay on the inputs after the pulse
  task automatic send_cmd(input dbg_mem_pkg::cmdtype_e t, input logic [23:0] ctrl);
    @(posedge clk_i);
    cmd_valid_i   <= 1'b1;
    cmdtype_i     <= t;
    cmd_control_i <= ctrl;
    @(negedge clk_i);
    capture_pulses();
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic wait_busy(input logic level);
    int cycles;
    cycles = 0;
    while (cmdbusy_o !== level && cycles < BusyTimeout) begin
      @(negedge clk_i);
      cycles++;
    end
    if (cmdbusy_o !== level) begin
      $display("timeout at %0t ns: cmdbusy_o never became %0b", $time, level);
      timeouts++;
    end
  endtask

  // hart runs the table and parks again
  task automatic finish_command();
    bus_write(32'(`DBG_GOING_ADDR), 32'd0, 4'hf);
    bus_write(32'(`DBG_HALTED_ADDR), 32'(hart), 4'hf);
    wait_busy(1'b0);
  endtask

  // --------------------
  // stimulus
  // --------------------
  initial begin
    logic [`DBG_PROGBUF_SIZE*32-1:0] pb;
    logic [63:0]                     dt;
    void'($urandom(82));
    errors   = 0;
    checks   = 0;
    timeouts = 0;
    hart       = $urandom % `DBG_NR_HARTS;
    other_hart = (hart + 1) % `DBG_NR_HARTS;
    for (int i = 0; i < `DBG_PROGBUF_SIZE; i++) begin
      pb[i*32 +: 32] = $urandom;
    end
    dt = {$urandom, $urandom};

    rst_ni            <= 1'b0;
    hartsel_i         <= `DBG_HARTSEL_W'(hart);
    haltreq_i         <= '0;
    resumereq_i       <= '0;
    clear_resumeack_i <= 1'b0;
    cmd_valid_i       <= 1'b0;
    cmdtype_i         <= dbg_mem_pkg::AccessRegister;
    cmd_control_i     <= '0;
    progbuf_i         <= pb;
    data_i            <= dt;
    req_i             <= 1'b0;
    we_i              <= 1'b0;
    addr_i            <= '0;
    wdata_i           <= '0;
    be_i              <= '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);

    // halt and status
    check_value(halted_o, 0, "halted_o after reset");
    check_value(resuming_o, 0, "resuming_o after reset");
    check_value(cmdbusy_o, 0, "cmdbusy_o after reset");
    check_value(rdata_o, 0, "rdata_o after reset");
    bus_write(32'(`DBG_HALTED_ADDR), 32'(hart), 4'hf);
    check_value(halted_o, 64'(1) << hart, "halted_o after halted write");
    bus_read(32'(`DBG_HALT_ADDR), 32'(hart), rd_word);
    check_value(rd_word, 0, "rom area read");
    bus_read(32'(`DBG_WHERETO_ADDR), 32'(hart), rd_word);
    check_value(rd_word, 0, "idle whereto");

    // gpr read command, table stores the register into data0
    gpr = $urandom % 32;
    send_cmd(dbg_mem_pkg::AccessRegister, make_control(1'b0, 1'b1, 1'b0, 16'h1000 | 16'(gpr)));
    check_value(err_valid_seen, 0, "no error on gpr read");
    check_value(cmdbusy_o, 1, "cmdbusy_o one cycle after cmd_valid_i");
    wait_busy(1'b1);
    bus_read(32'(`DBG_FLAGS_ADDR) + 32'(4 * (hart / 4)), 32'(hart), rd_word);
    check_value(rd_word, 64'(32'h1 << (8 * (hart % 4))), "go flag");
    bus_read(32'(`DBG_WHERETO_ADDR), 32'(hart), rd_word);
    check_value(rd_word, jal_word(21'(`DBG_ABSCMD_ADDR - `DBG_WHERETO_ADDR)), "whereto to table");
    bus_read(32'(`DBG_ABSCMD_ADDR + 16), 32'(hart), rd_word);
    check_value(rd_word, store_word(3'd2, 5'(gpr), `DBG_DATA_ADDR), "table word 4 store");
    bus_read(32'(`DBG_ABSCMD_ADDR), 32'(hart), rd_word);
    check_value(rd_word, NopWord, "table word 0");
    bus_write(32'(`DBG_GOING_ADDR), 32'd0, 4'hf);
    bus_read(32'(`DBG_FLAGS_ADDR) + 32'(4 * (hart / 4)), 32'(hart), rd_word);
    check_value(rd_word, 0, "flags while executing");
    bus_write(32'(`DBG_HALTED_ADDR), 32'(hart), 4'hf);
    wait_busy(1'b0);
    check_value(cmdbusy_o, 0, "cmdbusy_o after halted write");

    // gpr write command loads from data0
    gpr = $urandom % 32;
    send_cmd(dbg_mem_pkg::AccessRegister, make_control(1'b0, 1'b1, 1'b1, 16'h1000 | 16'(gpr)));
    wait_busy(1'b1);
    bus_read(32'(`DBG_ABSCMD_ADDR + 16), 32'(hart), rd_word);
    check_value(rd_word, load_word(3'd2, 5'(gpr), `DBG_DATA_ADDR), "table word 4 load");
    finish_command();

    // postexec without transfer jumps straight to the program buffer
    send_cmd(dbg_mem_pkg::AccessRegister, make_control(1'b1, 1'b0, 1'b0, 16'h1000));
    wait_busy(1'b1);
    bus_read(32'(`DBG_WHERETO_ADDR), 32'(hart), rd_word);
    check_value(rd_word, jal_word(21'(`DBG_PROGBUF_ADDR - `DBG_WHERETO_ADDR)),
                "whereto to program buffer");
    bus_read(32'(`DBG_ABSCMD_ADDR + 32), 32'(hart), rd_word);
    check_value(rd_word, NopWord, "table word 8 with postexec");
    for (int i = 0; i < `DBG_PROGBUF_SIZE; i++) begin
      bus_read(32'(`DBG_PROGBUF_ADDR + 4 * i), 32'(hart), rd_word);
      check_value(rd_word, pb[i*32 +: 32], "program buffer word");
    end
    finish_command();

    // --------------------
    // command errors
    // --------------------
    // mstatus is a csr, not handled here
    send_cmd(dbg_mem_pkg::AccessRegister, make_control(1'b0, 1'b1, 1'b0, 16'h0300));
    check_value(err_valid_seen, 1, "error pulse on csr access");
    check_value(err_seen, dbg_mem_pkg::CmdErrNotSupported, "csr access error code");
    check_value(cmdbusy_o, 0, "cmdbusy_o after unsupported command");
    bus_read(32'(`DBG_ABSCMD_ADDR), 32'(hart), rd_word);
    check_value(rd_word, EbreakWord, "table word 0 when unsupported");
    @(posedge clk_i);
    hartsel_i <= `DBG_HARTSEL_W'(other_hart);
    send_cmd(dbg_mem_pkg::AccessRegister, make_control(1'b0, 1'b1, 1'b0, 16'h1001));
    check_value(err_valid_seen, 1, "error pulse on running hart");
    check_value(err_seen, dbg_mem_pkg::CmdErrHaltResume, "running hart error code");
    check_value(cmdbusy_o, 0, "cmdbusy_o after command to running hart");
    @(posedge clk_i);
    hartsel_i <= `DBG_HARTSEL_W'(hart);
    bus_write(32'(`DBG_EXCEPTION_ADDR), 32'd0, 4'hf);
    check_value(err_valid_seen, 1, "error pulse on exception");
    check_value(err_seen, dbg_mem_pkg::CmdErrException, "exception error code");

    // resume handshake
    @(posedge clk_i);
    resumereq_i <= `DBG_NR_HARTS'(1) << hart;
    @(negedge clk_i);
    wait_busy(1'b1);
    bus_read(32'(`DBG_FLAGS_ADDR) + 32'(4 * (hart / 4)), 32'(hart), rd_word);
    check_value(rd_word, 64'(32'h2 << (8 * (hart % 4))), "resume flag");
    bus_write(32'(`DBG_RESUMING_ADDR), 32'(hart), 4'hf);
    check_value(halted_o, 0, "halted_o after resuming write");
    check_value(resuming_o, 64'(1) << hart, "resuming_o after resuming write");
    wait_busy(1'b0);
    bus_read(32'(`DBG_WHERETO_ADDR), 32'(hart), rd_word);
    check_value(rd_word, jal_word(21'(`DBG_RESUME_ADDR - `DBG_WHERETO_ADDR)), "whereto to resume");
    @(posedge clk_i);
    resumereq_i       <= '0;
    clear_resumeack_i <= 1'b1;
    @(posedge clk_i);
    clear_resumeack_i <= 1'b0;
    @(negedge clk_i);
    check_value(resuming_o, 0, "resuming_o after ack clear");

    // data registers, halt requests wiggle meanwhile
    for (int n = 0; n < 4; n++) begin
      idx     = $urandom % `DBG_DATA_COUNT;
      be      = 4'($urandom);
      wd_word = $urandom;
      @(posedge clk_i);
      haltreq_i <= `DBG_NR_HARTS'($urandom);
      bus_write(32'(`DBG_DATA_ADDR + 4 * idx), wd_word, be);
      check_value(data_valid_seen, 1, "data_valid_o on data write");
      check_value(data_seen, merge_bytes(dt, idx, wd_word, be), "data_o byte merge");
    end
    for (int i = 0; i < `DBG_DATA_COUNT; i++) begin
      bus_read(32'(`DBG_DATA_ADDR + 4 * i), 32'(hart), rd_word);
      check_value(rd_word, dt[i*32 +: 32], "data register read");
    end
    @(posedge clk_i);
    haltreq_i <= '0;
    @(negedge clk_i);

    $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+common
common/dbg_mem_pkg.sv
abstract_cmd/abstract_cmd_gen.sv
src/hart_ctrl_fsm.sv
src/dbg_mem_bus.sv
src/dbg_mem_top.sv
verification/tb_dbg_mem.sv

// File: run_sim.sh
#!/bin/sh
# compile with verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_dbg_mem -o sim_dbg_mem > build.log 2>&1 \
  || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_dbg_mem > sim.log 2>&1
grep -q "STATUS: PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
